// File: source/hazard_cfg.svh
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// register address width, enough for the 32 integer registers.
`define HZ_REG_W 5

// width of one RISC-V instruction word.
`define HZ_INSTR_W 32

`endif

// File: source/hazard_pkg.sv
`default_nettype none

`include "hazard_cfg.svh"

package hazard_pkg;

    // major opcodes the hazard logic has to tell apart.
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011
    } opcode_e;

    // operand bypass selects.
    // the first name is the producing stage and the second is where the value is picked up.
    typedef enum logic [3:0] {
        NO_BYPASS    = 4'd0,
        BY_EX_PIPE   = 4'd1,
        BY_EX_ID     = 4'd2,
        BY_MEM_ID    = 4'd3,
        BY_RVM5_ID   = 4'd4,
        BY_RVM5_PIPE = 4'd5,
        BY_MEM_PIPE  = 4'd6,
        BY_MEM_TL    = 4'd7,
        BY_RVM5_TL   = 4'd8
    } bypass_e;

    // one instruction word seen through two encodings.
    // R-type carries rd in bits 11:7, S-type carries the low immediate there instead.
    // both views keep rs1, rs2 and the opcode in the same place.
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [`HZ_REG_W-1:0] rs2;
            logic [`HZ_REG_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [`HZ_REG_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [6:0]           imm_hi;
            logic [`HZ_REG_W-1:0] rs2;
            logic [`HZ_REG_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_lo;
            logic [6:0]           opcode;
        } s;
    } rv_instr_u;

endpackage : hazard_pkg

`default_nettype wire

// File: source/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module instr_decoder (
    input  logic [`HZ_INSTR_W-1:0] instr_i,
    input  logic                   instr_valid_i,

    output logic [`HZ_REG_W-1:0]   src_a_o,
    output logic [`HZ_REG_W-1:0]   src_b_o,
    output logic [`HZ_REG_W-1:0]   dst_o,
    output hazard_pkg::opcode_e    opcode_o,
    output logic                   is_mul_o
);

import hazard_pkg::*;

rv_instr_u instr;
opcode_e   major;

assign instr = instr_i;
assign major = opcode_e'(instr.r.opcode);

// fields the format leaves unused stay zero, so they never match a tag downstream.
always_comb begin : decode
    src_a_o  = '0;
    src_b_o  = '0;
    dst_o    = '0;
    opcode_o = opcode_e'(7'd0);
    is_mul_o = 1'b0;

    if (instr_valid_i) begin
        opcode_o = major;

        case (major)
            OPCODE_OP: begin
                src_a_o  = instr.r.rs1;
                src_b_o  = instr.r.rs2;
                dst_o    = instr.r.rd;
                // funct7 of 1 selects the RVM group.
                is_mul_o = (instr.r.funct7 == 7'd1);
            end
            OPCODE_OP_IMM, OPCODE_LOAD: begin
                src_a_o = instr.r.rs1;
                dst_o   = instr.r.rd;
            end
            OPCODE_LUI, OPCODE_AUIPC: begin
                dst_o = instr.r.rd;
            end
            OPCODE_STORE, OPCODE_BRANCH: begin
                // bits 11:7 hold immediate here, not a destination.
                src_a_o = instr.s.rs1;
                src_b_o = instr.s.rs2;
            end
            default: begin
                src_a_o = '0;
                src_b_o = '0;
                dst_o   = '0;
            end
        endcase
    end
end

endmodule : instr_decoder

`default_nettype wire

// File: source/pipeline_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module pipeline_tracker (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // instruction leaving decode this cycle
    input  logic                 issue_i,
    input  logic [`HZ_REG_W-1:0] dst_i,
    input  hazard_pkg::opcode_e  opcode_i,
    input  logic                 is_mul_i,

    // entry in ID
    output logic [`HZ_REG_W-1:0] dst_id_o,
    output hazard_pkg::opcode_e  id_opcode_o,
    output logic                 id_is_mul_o,

    // stage destination tags
    output logic [`HZ_REG_W-1:0] ex_wreg_o,
    output logic [`HZ_REG_W-1:0] mem_wreg_o,
    output logic [`HZ_REG_W-1:0] alu_mem_wreg_o,
    output logic [`HZ_REG_W-1:0] tl_wreg_o,
    output logic [`HZ_REG_W-1:0] rvm1_wreg_o,
    output logic [`HZ_REG_W-1:0] rvm2_wreg_o,
    output logic [`HZ_REG_W-1:0] rvm3_wreg_o,
    output logic [`HZ_REG_W-1:0] rvm4_wreg_o,
    output logic [`HZ_REG_W-1:0] rvm5_wreg_o
);

import hazard_pkg::*;

logic to_alu;
logic to_load;
logic to_mul;

// lane the ID entry enters on the next edge.
always_comb begin : lane_select
    to_mul  = id_is_mul_o;
    to_load = (id_opcode_o == OPCODE_LOAD);
    to_alu  = ((id_opcode_o == OPCODE_OP || id_opcode_o == OPCODE_OP_IMM) && !id_is_mul_o) ||
              id_opcode_o == OPCODE_LUI || id_opcode_o == OPCODE_AUIPC;
end

always_ff @(posedge clk_i) begin : id_stage
    if (!rst_n_i) begin
        dst_id_o    <= '0;
        id_opcode_o <= opcode_e'(7'd0);
        id_is_mul_o <= 1'b0;
    end
    else if (issue_i) begin
        dst_id_o    <= dst_i;
        id_opcode_o <= opcode_i;
        id_is_mul_o <= is_mul_i;
    end
    else begin
        // a bubble enters ID when nothing issues.
        dst_id_o    <= '0;
        id_opcode_o <= opcode_e'(7'd0);
        id_is_mul_o <= 1'b0;
    end
end

always_ff @(posedge clk_i) begin : lanes
    if (!rst_n_i) begin
        ex_wreg_o      <= '0;
        mem_wreg_o     <= '0;
        alu_mem_wreg_o <= '0;
        tl_wreg_o      <= '0;
        rvm1_wreg_o    <= '0;
        rvm2_wreg_o    <= '0;
        rvm3_wreg_o    <= '0;
        rvm4_wreg_o    <= '0;
        rvm5_wreg_o    <= '0;
    end
    else begin
        ex_wreg_o      <= to_alu ? dst_id_o : '0;
        mem_wreg_o     <= ex_wreg_o;

        alu_mem_wreg_o <= to_load ? dst_id_o : '0;
        tl_wreg_o      <= alu_mem_wreg_o;

        rvm1_wreg_o    <= to_mul ? dst_id_o : '0;
        rvm2_wreg_o    <= rvm1_wreg_o;
        rvm3_wreg_o    <= rvm2_wreg_o;
        rvm4_wreg_o    <= rvm3_wreg_o;
        rvm5_wreg_o    <= rvm4_wreg_o;
    end
end

endmodule : pipeline_tracker

`default_nettype wire

// File: source/bypass_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module bypass_controller (
    input  logic                 rst_n_i,

    // pending instruction
    input  logic [`HZ_REG_W-1:0] src_a_i,
    input  logic [`HZ_REG_W-1:0] src_b_i,
    input  hazard_pkg::opcode_e  instr_opcode_i,

    // producer in ID, a multiply arrives here as a load
    input  logic [`HZ_REG_W-1:0] dst_id_i,
    input  hazard_pkg::opcode_e  id_opcode_i,

    // downstream tags
    input  logic [`HZ_REG_W-1:0] ex_wreg_i,
    input  logic [`HZ_REG_W-1:0] mem_wreg_i,
    input  logic [`HZ_REG_W-1:0] alu_mem_wreg_i,
    input  logic [`HZ_REG_W-1:0] tl_wreg_i,
    input  logic [`HZ_REG_W-1:0] rvm1_wreg_i,
    input  logic [`HZ_REG_W-1:0] rvm2_wreg_i,
    input  logic [`HZ_REG_W-1:0] rvm3_wreg_i,
    input  logic [`HZ_REG_W-1:0] rvm4_wreg_i,
    input  logic [`HZ_REG_W-1:0] rvm5_wreg_i,

    output hazard_pkg::bypass_e  bypass_a_o,
    output hazard_pkg::bypass_e  bypass_b_o,
    output logic                 dependence_o
);

import hazard_pkg::*;

logic dep_a;
logic dep_b;
logic id_fwd_a;
logic id_fwd_b;

// an immediate-form ALU op in ID cannot feed operand b from the EX output.
assign id_fwd_a = (id_opcode_i == OPCODE_OP)  || (id_opcode_i == OPCODE_OP_IMM) ||
                  (id_opcode_i == OPCODE_LUI) || (id_opcode_i == OPCODE_AUIPC);
assign id_fwd_b = (id_opcode_i == OPCODE_OP)  || (id_opcode_i == OPCODE_LUI) ||
                  (id_opcode_i == OPCODE_AUIPC);

assign dependence_o = dep_a | dep_b;

always_comb begin : operand_a
    dep_a      = 1'b0;
    bypass_a_o = NO_BYPASS;

    if (rst_n_i && src_a_i != '0) begin
        if (src_a_i == dst_id_i) begin
            if (id_fwd_a) begin
                bypass_a_o = BY_EX_PIPE;
            end
            else begin
                dep_a = 1'b1;
            end
        end
        else if (src_a_i == ex_wreg_i) begin
            bypass_a_o = BY_EX_ID;
        end
        else if (src_a_i == mem_wreg_i) begin
            bypass_a_o = BY_MEM_ID;
        end
        else if (src_a_i == rvm5_wreg_i) begin
            bypass_a_o = BY_RVM5_ID;
        end
        else if (src_a_i == rvm4_wreg_i) begin
            bypass_a_o = BY_RVM5_PIPE;
        end
        else if (src_a_i == tl_wreg_i) begin
            bypass_a_o = BY_MEM_PIPE;
        end
        else if (src_a_i == alu_mem_wreg_i ||
                 src_a_i == rvm1_wreg_i    ||
                 src_a_i == rvm2_wreg_i    ||
                 src_a_i == rvm3_wreg_i) begin
            dep_a = 1'b1;
        end
    end
end

always_comb begin : operand_b
    dep_b      = 1'b0;
    bypass_b_o = NO_BYPASS;

    if (rst_n_i && src_b_i != '0) begin
        if (src_b_i == dst_id_i) begin
            if (id_fwd_b) begin
                bypass_b_o = BY_EX_PIPE;
            end
            else begin
                dep_b = 1'b1;
            end
        end
        // load data in tag lookup can still reach operand b one stage later.
        else if (src_b_i == alu_mem_wreg_i) begin
            bypass_b_o = BY_MEM_TL;
        end
        else if (src_b_i == ex_wreg_i) begin
            bypass_b_o = BY_EX_ID;
        end
        else if (src_b_i == mem_wreg_i) begin
            bypass_b_o = BY_MEM_ID;
        end
        else if (src_b_i == rvm5_wreg_i) begin
            bypass_b_o = BY_RVM5_ID;
        end
        else if (src_b_i == rvm4_wreg_i) begin
            bypass_b_o = BY_RVM5_PIPE;
        end
        else if (src_b_i == tl_wreg_i) begin
            bypass_b_o = BY_MEM_PIPE;
        end
        else if (src_b_i == rvm3_wreg_i && instr_opcode_i == OPCODE_STORE) begin
            // store data is needed late, so rvm5 output is caught in TL.
            bypass_b_o = BY_RVM5_TL;
        end
        else if (src_b_i == rvm1_wreg_i ||
                 src_b_i == rvm2_wreg_i ||
                 src_b_i == rvm3_wreg_i) begin
            dep_b = 1'b1;
        end
    end
end

endmodule : bypass_controller

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module hazard_unit (
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    input  logic [`HZ_INSTR_W-1:0] instr_i,
    input  logic                   instr_valid_i,

    output hazard_pkg::bypass_e    bypass_a_o,
    output hazard_pkg::bypass_e    bypass_b_o,
    output logic                   stall_o
);

import hazard_pkg::*;

logic [`HZ_REG_W-1:0] src_a;
logic [`HZ_REG_W-1:0] src_b;
logic [`HZ_REG_W-1:0] dst;
opcode_e              instr_opcode;
logic                 is_mul;

logic                 issue;
logic                 dependence;

logic [`HZ_REG_W-1:0] dst_id;
opcode_e              id_opcode;
opcode_e              id_opcode_eff;
logic                 id_is_mul;

logic [`HZ_REG_W-1:0] ex_wreg;
logic [`HZ_REG_W-1:0] mem_wreg;
logic [`HZ_REG_W-1:0] alu_mem_wreg;
logic [`HZ_REG_W-1:0] tl_wreg;
logic [`HZ_REG_W-1:0] rvm1_wreg;
logic [`HZ_REG_W-1:0] rvm2_wreg;
logic [`HZ_REG_W-1:0] rvm3_wreg;
logic [`HZ_REG_W-1:0] rvm4_wreg;
logic [`HZ_REG_W-1:0] rvm5_wreg;

assign issue   = instr_valid_i & ~dependence;
assign stall_o = instr_valid_i & dependence;

// a multiply in ID decodes as OP but its result is far off, so treat it like a load.
assign id_opcode_eff = id_is_mul ? OPCODE_LOAD : id_opcode;

instr_decoder u_decoder (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .src_a_o       (src_a),
    .src_b_o       (src_b),
    .dst_o         (dst),
    .opcode_o      (instr_opcode),
    .is_mul_o      (is_mul)
);

pipeline_tracker u_tracker (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_i        (issue),
    .dst_i          (dst),
    .opcode_i       (instr_opcode),
    .is_mul_i       (is_mul),
    .dst_id_o       (dst_id),
    .id_opcode_o    (id_opcode),
    .id_is_mul_o    (id_is_mul),
    .ex_wreg_o      (ex_wreg),
    .mem_wreg_o     (mem_wreg),
    .alu_mem_wreg_o (alu_mem_wreg),
    .tl_wreg_o      (tl_wreg),
    .rvm1_wreg_o    (rvm1_wreg),
    .rvm2_wreg_o    (rvm2_wreg),
    .rvm3_wreg_o    (rvm3_wreg),
    .rvm4_wreg_o    (rvm4_wreg),
    .rvm5_wreg_o    (rvm5_wreg)
);

bypass_controller u_bypass (
    .rst_n_i        (rst_n_i),
    .src_a_i        (src_a),
    .src_b_i        (src_b),
    .instr_opcode_i (instr_opcode),
    .dst_id_i       (dst_id),
    .id_opcode_i    (id_opcode_eff),
    .ex_wreg_i      (ex_wreg),
    .mem_wreg_i     (mem_wreg),
    .alu_mem_wreg_i (alu_mem_wreg),
    .tl_wreg_i      (tl_wreg),
    .rvm1_wreg_i    (rvm1_wreg),
    .rvm2_wreg_i    (rvm2_wreg),
    .rvm3_wreg_i    (rvm3_wreg),
    .rvm4_wreg_i    (rvm4_wreg),
    .rvm5_wreg_i    (rvm5_wreg),
    .bypass_a_o     (bypass_a_o),
    .bypass_b_o     (bypass_b_o),
    .dependence_o   (dependence)
);

endmodule : hazard_unit

`default_nettype wire

// File: sim/hazard_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module hazard_unit_assert (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 instr_valid_i,
    input logic [`HZ_REG_W-1:0] src_a_i,
    input logic [`HZ_REG_W-1:0] src_b_i,
    input hazard_pkg::bypass_e  bypass_a_i,
    input hazard_pkg::bypass_e  bypass_b_i,
    input logic                 stall_i
);

import hazard_pkg::*;

// the unit is silent while the core is held in reset.
quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (bypass_a_i == NO_BYPASS && bypass_b_i == NO_BYPASS && !stall_i))
    else $error("bypass or stall active during reset");

stall_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stall_i |-> instr_valid_i)
    else $error("stall raised without a valid instruction");

// x0 is never produced, so a zero source needs no bypass.
zero_src_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (src_a_i == '0) |-> (bypass_a_i == NO_BYPASS))
    else $error("bypass on operand a with source x0");

zero_src_b: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (src_b_i == '0) |-> (bypass_b_i == NO_BYPASS))
    else $error("bypass on operand b with source x0");

endmodule : hazard_unit_assert

bind hazard_unit hazard_unit_assert u_assert (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .src_a_i       (src_a),
    .src_b_i       (src_b),
    .bypass_a_i    (bypass_a_o),
    .bypass_b_i    (bypass_b_o),
    .stall_i       (stall_o)
);

`default_nettype wire

// File: sim/hazard_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hazard_cfg.svh"

module hazard_unit_tb;

import hazard_pkg::*;

localparam int N_RANDOM        = 2000;
localparam int N_DIRECTED      = 100;
localparam int WATCHDOG_CYCLES = (N_RANDOM + N_DIRECTED) * 8 + 100;

logic                   clk_i;
logic                   rst_n_i;
logic [`HZ_INSTR_W-1:0] instr_i;
logic                   instr_valid_i;
bypass_e                bypass_a_o;
bypass_e                bypass_b_o;
logic                   stall_o;

int      errors;
int      checks;
bit      hold_reset;
bypass_e obs_a;
bypass_e obs_b;
logic    obs_stall;
logic    m_stall;

// reference copy of the tracker lanes.
logic [`HZ_REG_W-1:0] m_id_dst;
logic [6:0]           m_id_op;
bit                   m_id_mul;
logic [`HZ_REG_W-1:0] m_ex;
logic [`HZ_REG_W-1:0] m_mem;
logic [`HZ_REG_W-1:0] m_am;
logic [`HZ_REG_W-1:0] m_tl;
logic [`HZ_REG_W-1:0] m_rvm [1:5];

hazard_unit dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .bypass_a_o    (bypass_a_o),
    .bypass_b_o    (bypass_b_o),
    .stall_o       (stall_o)
);

initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
end

initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
end

function automatic logic [`HZ_INSTR_W-1:0] encode(input opcode_e op, input int rd,
                                                  input int rs1, input int rs2, input bit mul);
    return {6'd0, mul, rs2[`HZ_REG_W-1:0], rs1[`HZ_REG_W-1:0], 3'd0, rd[`HZ_REG_W-1:0], op};
endfunction

function automatic logic [`HZ_INSTR_W-1:0] random_instr();
    opcode_e                ops [0:6] = '{OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC,
                                          OPCODE_LOAD, OPCODE_STORE, OPCODE_BRANCH};
    logic [`HZ_INSTR_W-1:0] w;
    w        = $urandom;
    w[6:0]   = ops[$urandom_range(0, 6)];
    w[11:7]  = $urandom_range(0, 7);
    w[19:15] = $urandom_range(0, 7);
    w[24:20] = $urandom_range(0, 7);
    w[31:25] = $urandom_range(0, 1);
    return w;
endfunction

task automatic decode_ref(input logic [`HZ_INSTR_W-1:0] w, input logic v,
                          output logic [`HZ_REG_W-1:0] sa, output logic [`HZ_REG_W-1:0] sb,
                          output logic [`HZ_REG_W-1:0] d, output logic [6:0] op, output bit mul);
    op  = v ? w[6:0] : 7'd0;
    sa  = (!v || op inside {OPCODE_LUI, OPCODE_AUIPC}) ? '0 : w[19:15];
    sb  = (!v || op inside {OPCODE_OP_IMM, OPCODE_LOAD, OPCODE_LUI, OPCODE_AUIPC}) ? '0 : w[24:20];
    d   = (!v || op inside {OPCODE_STORE, OPCODE_BRANCH}) ? '0 : w[11:7];
    mul = (op == OPCODE_OP) && (w[31:25] == 7'd1);
endtask

// operand b also takes load data in tag lookup, and late multiply data for a store.
function automatic bypass_e predict(input logic [`HZ_REG_W-1:0] src, input bit is_b,
                                    input bit store, output bit dep);
    bit      fwd;
    bypass_e sel;
    fwd = !m_id_mul && ((m_id_op inside {OPCODE_OP, OPCODE_LUI, OPCODE_AUIPC}) ||
                        (!is_b && m_id_op == OPCODE_OP_IMM));
    sel = NO_BYPASS;
    dep = 1'b0;
    if (src == '0) begin
        sel = NO_BYPASS;
    end
    else if (src == m_id_dst) begin
        sel = fwd ? BY_EX_PIPE : NO_BYPASS;
        dep = !fwd;
    end
    else if (is_b && src == m_am) begin
        sel = BY_MEM_TL;
    end
    else if (src == m_ex) begin
        sel = BY_EX_ID;
    end
    else if (src == m_mem) begin
        sel = BY_MEM_ID;
    end
    else if (src == m_rvm[5]) begin
        sel = BY_RVM5_ID;
    end
    else if (src == m_rvm[4]) begin
        sel = BY_RVM5_PIPE;
    end
    else if (src == m_tl) begin
        sel = BY_MEM_PIPE;
    end
    else if (is_b && store && src == m_rvm[3]) begin
        sel = BY_RVM5_TL;
    end
    else begin
        dep = (src == m_am) || (src == m_rvm[1]) || (src == m_rvm[2]) || (src == m_rvm[3]);
    end
    return sel;
endfunction

task automatic clear_model();
    m_id_dst = '0;
    m_id_op  = '0;
    m_id_mul = 1'b0;
    m_ex     = '0;
    m_mem    = '0;
    m_am     = '0;
    m_tl     = '0;
    for (int k = 1; k <= 5; k++) begin
        m_rvm[k] = '0;
    end
endtask

task automatic advance_model(input bit issue, input logic [`HZ_REG_W-1:0] d,
                             input logic [6:0] op, input bit mul);
    bit alu;
    if (!rst_n_i) begin
        clear_model();
    end
    else begin
        alu = !m_id_mul && (m_id_op inside {OPCODE_OP, OPCODE_OP_IMM, OPCODE_LUI, OPCODE_AUIPC});
        for (int k = 5; k > 1; k--) begin
            m_rvm[k] = m_rvm[k-1];
        end
        m_rvm[1] = m_id_mul ? m_id_dst : '0;
        m_tl     = m_am;
        m_am     = (m_id_op == OPCODE_LOAD) ? m_id_dst : '0;
        m_mem    = m_ex;
        m_ex     = alu ? m_id_dst : '0;
        m_id_dst = issue ? d : '0;
        m_id_op  = issue ? op : '0;
        m_id_mul = issue && mul;
    end
endtask

task automatic check_bypass(input string name, input bypass_e exp, input bypass_e act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR at %0t: %s expected %s (%0d) got %s (%0d)",
                 $time, name, exp.name(), exp, act.name(), act);
    end
endtask

task automatic check_stall(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERROR at %0t: stall_o expected %b got %b", $time, exp, act);
    end
endtask

// one clock: drive on the falling edge, check before the rising edge, then step the model.
task automatic cycle(input logic [`HZ_INSTR_W-1:0] w, input logic v);
    logic [`HZ_REG_W-1:0] sa;
    logic [`HZ_REG_W-1:0] sb;
    logic [`HZ_REG_W-1:0] d;
    logic [6:0]           op;
    bit                   mul;
    bit                   dep_a;
    bit                   dep_b;
    bypass_e              exp_a;
    bypass_e              exp_b;
    @(negedge clk_i);
    rst_n_i       = !hold_reset;
    instr_i       = w;
    instr_valid_i = v;
    decode_ref(w, v, sa, sb, d, op, mul);
    exp_a   = predict(sa, 1'b0, 1'b0, dep_a);
    exp_b   = predict(sb, 1'b1, op == OPCODE_STORE, dep_b);
    m_stall = v && (dep_a || dep_b);
    if (!rst_n_i) begin
        exp_a   = NO_BYPASS;
        exp_b   = NO_BYPASS;
        m_stall = 1'b0;
    end
    #2;
    obs_a     = bypass_a_o;
    obs_b     = bypass_b_o;
    obs_stall = stall_o;
    check_bypass("bypass_a_o", exp_a, obs_a);
    check_bypass("bypass_b_o", exp_b, obs_b);
    check_stall(m_stall, obs_stall);
    @(posedge clk_i);
    advance_model(v && !m_stall, d, op, mul);
endtask

task automatic cycle_expect(input logic [`HZ_INSTR_W-1:0] w, input bypass_e a,
                            input bypass_e b, input logic st);
    cycle(w, 1'b1);
    check_bypass("bypass_a_o", a, obs_a);
    check_bypass("bypass_b_o", b, obs_b);
    check_stall(st, obs_stall);
endtask

task automatic drain();
    repeat (7) cycle('0, 1'b0);
endtask

task automatic report_test(input string name, input int base);
    $display("test %s: %0d errors", name, errors - base);
endtask

initial begin
    int                     base;
    logic [`HZ_INSTR_W-1:0] w;
    void'($urandom(27559));
    errors        = 0;
    checks        = 0;
    hold_reset    = 1'b1;
    rst_n_i       = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    m_stall       = 1'b0;
    clear_model();

    // a dependent pair and a load are presented while reset is held.
    base = errors;
    cycle_expect(encode(OPCODE_OP, 3, 1, 2, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 4, 3, 3, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_LOAD, 3, 1, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    hold_reset = 1'b0;
    cycle_expect(encode(OPCODE_OP, 4, 3, 3, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_LOAD, 5, 1, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    // reset again with an OP and a load in flight, so this reader would otherwise match both.
    hold_reset = 1'b1;
    cycle_expect(encode(OPCODE_OP, 6, 5, 4, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    hold_reset = 1'b0;
    cycle_expect(encode(OPCODE_OP, 6, 5, 4, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    report_test("reset", base);

    base = errors;
    drain();
    cycle_expect(encode(OPCODE_OP, 3, 1, 2, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 4, 3, 3, 0), BY_EX_PIPE, BY_EX_PIPE, 1'b0);
    cycle_expect(encode(OPCODE_OP, 5, 3, 3, 0), BY_EX_ID, BY_EX_ID, 1'b0);
    cycle_expect(encode(OPCODE_OP, 6, 3, 3, 0), BY_MEM_ID, BY_MEM_ID, 1'b0);
    drain();
    cycle_expect(encode(OPCODE_OP_IMM, 3, 1, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 4, 3, 3, 0), BY_EX_PIPE, NO_BYPASS, 1'b1);
    cycle_expect(encode(OPCODE_OP, 4, 3, 3, 0), BY_EX_ID, BY_EX_ID, 1'b0);
    report_test("alu_chain", base);

    base = errors;
    drain();
    cycle_expect(encode(OPCODE_LOAD, 3, 1, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 4, 0, 3, 0), NO_BYPASS, NO_BYPASS, 1'b1);
    cycle_expect(encode(OPCODE_OP, 4, 0, 3, 0), NO_BYPASS, BY_MEM_TL, 1'b0);
    drain();
    cycle_expect(encode(OPCODE_LOAD, 3, 1, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    repeat (2) cycle_expect(encode(OPCODE_OP, 4, 3, 0, 0), NO_BYPASS, NO_BYPASS, 1'b1);
    cycle_expect(encode(OPCODE_OP, 4, 3, 0, 0), BY_MEM_PIPE, NO_BYPASS, 1'b0);
    report_test("load_use", base);

    base = errors;
    drain();
    cycle_expect(encode(OPCODE_OP, 3, 1, 2, 1), NO_BYPASS, NO_BYPASS, 1'b0);
    repeat (4) cycle_expect(encode(OPCODE_OP, 4, 3, 0, 0), NO_BYPASS, NO_BYPASS, 1'b1);
    cycle_expect(encode(OPCODE_OP, 4, 3, 0, 0), BY_RVM5_PIPE, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 5, 3, 3, 0), BY_RVM5_ID, BY_RVM5_ID, 1'b0);
    drain();
    cycle_expect(encode(OPCODE_OP, 3, 1, 2, 1), NO_BYPASS, NO_BYPASS, 1'b0);
    repeat (3) cycle('0, 1'b0);
    cycle_expect(encode(OPCODE_STORE, 4, 1, 3, 0), NO_BYPASS, BY_RVM5_TL, 1'b0);
    report_test("mul_chain", base);

    // every register field below would match a producer if it were decoded.
    base = errors;
    drain();
    cycle_expect(encode(OPCODE_OP, 3, 1, 2, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP_IMM, 6, 1, 3, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_LOAD, 7, 2, 3, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_LUI, 2, 6, 7, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_STORE, 4, 0, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_BRANCH, 5, 4, 0, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    cycle_expect(encode(OPCODE_OP, 1, 4, 5, 0), NO_BYPASS, NO_BYPASS, 1'b0);
    report_test("unused_fields", base);

    base = errors;
    for (int i = 0; i < N_RANDOM; i++) begin
        w = random_instr();
        if ($urandom_range(0, 7) == 0) begin
            cycle($urandom, 1'b0);
        end
        cycle(w, 1'b1);
        while (m_stall) begin
            cycle(w, 1'b1);
        end
    end
    report_test("random", base);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end
    else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule : hazard_unit_tb

`default_nettype wire

// File: files.f
+incdir+source
source/hazard_pkg.sv
source/instr_decoder.sv
source/pipeline_tracker.sv
source/bypass_controller.sv
source/hazard_unit.sv
sim/hazard_unit_assert.sv
sim/hazard_unit_tb.sv
